// ==== build.f ====
obi_pkg.sv
mem_pkg.sv
obi_if.sv
obi_rr_arbiter.sv
obi_id_fifo.sv
obi_mux.sv
obi_sram.sv
obi_mux_top.sv
tb_obi_mux_top.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, then judge the result from the simulation log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_obi_mux_top \
  -o tb_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "simulation ended with an error status"
grep -qF "*** TEST FAILED ***" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log && echo "PASS" || { echo "FAIL, no result"; exit 1; }

// ==== tb_obi_mux_top.sv ====
// Random-traffic testbench for the OBI mux subsystem.
// Three ports share the SRAM. A reference memory and per-port queues of
// expected responses check data, routing, fairness and back-pressure.
`timescale 1ns/10ps
`default_nettype none

module tb_obi_mux_top;

  localparam int NumSbrPorts   = 3;
  localparam int NumMaxTrans   = 4;
  localparam int MemWords      = 64;
  localparam int NumTrans      = 2000;
  localparam int TimeoutCycles = NumTrans * 8 * NumSbrPorts;

  // expected response with a mask of the bytes whose value is known
  typedef struct packed {
    logic [31:0] rdata;
    logic [31:0] mask;
    logic [1:0]  rid;
    logic        err;
  } exp_t;

  logic                         clk;
  logic                         rst;
  logic [NumSbrPorts-1:0]       req, we, rready;
  logic [NumSbrPorts-1:0][31:0] addr, wdata;
  logic [NumSbrPorts-1:0][3:0]  be;
  logic [NumSbrPorts-1:0][1:0]  aid;
  logic [NumSbrPorts-1:0]       gnt, rvalid, err;
  logic [NumSbrPorts-1:0][31:0] rdata;
  logic [NumSbrPorts-1:0][1:0]  rid;

  // reference model state
  logic [31:0] ref_mem [MemWords];
  logic [3:0]  known [MemWords] = '{default: 4'h0};
  exp_t        exp_q [NumSbrPorts][$];
  int          wait_gnts [NumSbrPorts][NumSbrPorts] = '{default: 0};
  logic [NumSbrPorts-1:0] gnt_seen;
  logic [NumSbrPorts-1:0] held;
  logic [31:0] held_rdata [NumSbrPorts];
  logic [1:0]  held_rid [NumSbrPorts];
  int issued      = 0;
  int rsp_count   = 0;
  int outstanding = 0;
  int cycle_cnt   = 0;

  obi_mux_top #(
    .NumSbrPorts(NumSbrPorts),
    .NumMaxTrans(NumMaxTrans),
    .MemWords   (MemWords)
  ) i_dut (
    .clk_i   (clk),
    .rst_i   (rst),
    .req_i   (req),
    .addr_i  (addr),
    .we_i    (we),
    .be_i    (be),
    .wdata_i (wdata),
    .aid_i   (aid),
    .gnt_o   (gnt),
    .rvalid_o(rvalid),
    .rready_i(rready),
    .rdata_o (rdata),
    .rid_o   (rid),
    .err_o   (err)
  );

  task automatic value_error(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    $display("error: %s expected %h actual %h", test_name, expected, actual);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  // mostly inside the memory and one in eight beyond it
  function automatic logic [31:0] pick_addr();
    logic [29:0] word;
    if ($urandom % 8 == 0) begin
      word = 30'(MemWords + $urandom % 256);
    end else begin
      word = 30'($urandom % MemWords);
    end
    return {word, 2'($urandom)};
  endfunction

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // new request once the previous one was granted
  initial begin : drive
    void'($urandom(32'h554c_1d65));
    forever begin
      @(posedge clk);
      if (!rst) begin
        for (int p = 0; p < NumSbrPorts; p++) begin
          if (!req[p] || gnt_seen[p]) begin
            if (issued < NumTrans && $urandom % 3 != 0) begin
              req[p]   <= 1'b1;
              addr[p]  <= pick_addr();
              we[p]    <= 1'($urandom);
              be[p]    <= 4'($urandom);
              wdata[p] <= $urandom;
              aid[p]   <= 2'($urandom);
              issued++;
            end else begin
              req[p] <= 1'b0;
            end
          end
          rready[p] <= ($urandom % 4 != 0);
        end
      end
    end
  end

  // sampled mid-cycle to see the transfers of the coming edge
  always @(negedge clk) begin : monitor
    exp_t        e;
    logic [29:0] widx;
    string       name;
    if (rst) begin
      gnt_seen = '0;
      held     = '0;
    end else begin
      assert ($onehot0(gnt)) else abort_run("more than one port granted in one cycle");
      for (int p = 0; p < NumSbrPorts; p++) begin
        if (!req[p]) begin
          for (int k = 0; k < NumSbrPorts; k++) wait_gnts[p][k] = 0;
        end
      end
      for (int q = 0; q < NumSbrPorts; q++) begin
        gnt_seen[q] = req[q] && gnt[q];
        if (gnt_seen[q]) begin
          // every other waiting port counts this grant
          for (int p = 0; p < NumSbrPorts; p++) begin
            if (p != q && req[p]) begin
              wait_gnts[p][q]++;
              assert (wait_gnts[p][q] <= 1)
                else value_error("arbitration", 1, wait_gnts[p][q]);
            end
          end
          for (int k = 0; k < NumSbrPorts; k++) wait_gnts[q][k] = 0;
          // model in global grant order
          widx    = addr[q][31:2];
          e.rid   = aid[q];
          e.err   = (widx >= 30'(MemWords));
          e.rdata = '0;
          e.mask  = '1;
          if (!e.err && mem_pkg::mem_op_e'(we[q]) == mem_pkg::MEM_WRITE) begin
            for (int b = 0; b < 4; b++) begin
              if (be[q][b]) begin
                ref_mem[widx][8*b +: 8] = wdata[q][8*b +: 8];
                known[widx][b]          = 1'b1;
              end
            end
          end else if (!e.err) begin
            e.rdata = ref_mem[widx];
            for (int b = 0; b < 4; b++) e.mask[8*b +: 8] = {8{known[widx][b]}};
          end
          exp_q[q].push_back(e);
          outstanding++;
        end
      end
      for (int p = 0; p < NumSbrPorts; p++) begin
        // stalled response must hold
        if (held[p]) begin
          assert (rvalid[p])
            else abort_run($sformatf("port %0d dropped a stalled response", p));
          assert (rdata[p] === held_rdata[p])
            else value_error("back_pressure", held_rdata[p], rdata[p]);
          assert (rid[p] === held_rid[p])
            else value_error("back_pressure", 32'(held_rid[p]), 32'(rid[p]));
        end
        if (rvalid[p] && rready[p]) begin
          assert (exp_q[p].size() > 0)
            else abort_run($sformatf("port %0d got a response it never requested", p));
          e    = exp_q[p].pop_front();
          name = e.err ? "out_of_range" : "read_after_write";
          assert (err[p] === e.err) else value_error(name, 32'(e.err), 32'(err[p]));
          assert ((rdata[p] & e.mask) === (e.rdata & e.mask))
            else value_error(name, e.rdata & e.mask, rdata[p] & e.mask);
          assert (rid[p] === e.rid) else value_error("routing", 32'(e.rid), 32'(rid[p]));
          outstanding--;
          rsp_count++;
        end
        held[p]       = rvalid[p] && !rready[p];
        held_rdata[p] = rdata[p];
        held_rid[p]   = rid[p];
      end
      assert (outstanding <= NumMaxTrans)
        else value_error("outstanding", NumMaxTrans, outstanding);
    end
  end

  always @(posedge clk) begin : watchdog
    cycle_cnt++;
    if (cycle_cnt > TimeoutCycles) begin
      $display("timeout: %0d of %0d responses seen after %0d cycles",
               rsp_count, NumTrans, TimeoutCycles);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation timed out");
    end
  end

  initial begin : main
    rst    <= 1'b1;
    req    <= '0;
    addr   <= '0;
    we     <= '0;
    be     <= '0;
    wdata  <= '0;
    aid    <= '0;
    rready <= '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    wait (rsp_count == NumTrans);
    repeat (4) @(posedge clk);
    for (int p = 0; p < NumSbrPorts; p++) begin
      assert (exp_q[p].size() == 0)
        else abort_run($sformatf("port %0d still waits for responses", p));
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== obi_mux_top.sv ====
// Top level of the OBI mux subsystem with flattened per-port signals.
// Each port group drives one mux input; the mux output feeds the SRAM.
`timescale 1ns/10ps
`default_nettype none

module obi_mux_top #(
  parameter int unsigned NumSbrPorts = 3,
  parameter int unsigned NumMaxTrans = 4,
  parameter int unsigned MemWords    = 64
) (
  input  wire logic clk_i,
  input  wire logic rst_i,
  input  wire logic [NumSbrPorts-1:0]                               req_i,
  input  wire logic [NumSbrPorts-1:0][obi_pkg::ObiAddrWidth-1:0]    addr_i,
  input  wire logic [NumSbrPorts-1:0]                               we_i,
  input  wire logic [NumSbrPorts-1:0][obi_pkg::ObiDataWidth/8-1:0]  be_i,
  input  wire logic [NumSbrPorts-1:0][obi_pkg::ObiDataWidth-1:0]    wdata_i,
  input  wire logic [NumSbrPorts-1:0][obi_pkg::ObiSbrIdWidth-1:0]   aid_i,
  output      logic [NumSbrPorts-1:0]                               gnt_o,
  output      logic [NumSbrPorts-1:0]                               rvalid_o,
  input  wire logic [NumSbrPorts-1:0]                               rready_i,
  output      logic [NumSbrPorts-1:0][obi_pkg::ObiDataWidth-1:0]    rdata_o,
  output      logic [NumSbrPorts-1:0][obi_pkg::ObiSbrIdWidth-1:0]   rid_o,
  output      logic [NumSbrPorts-1:0]                               err_o
);

  localparam int unsigned IdPad = obi_pkg::ObiMaxIdWidth - obi_pkg::ObiSbrIdWidth;

  obi_if sbr_bus [NumSbrPorts] ();
  obi_if mem_bus ();

  // flat ports to and from the bus bundles
  for (genvar i = 0; i < NumSbrPorts; i++) begin : gen_port
    assign sbr_bus[i].req     = req_i[i];
    assign sbr_bus[i].a.addr  = addr_i[i];
    assign sbr_bus[i].a.we    = we_i[i];
    assign sbr_bus[i].a.be    = be_i[i];
    assign sbr_bus[i].a.wdata = wdata_i[i];
    // upper id bits belong to the mux
    assign sbr_bus[i].a.aid   = {{IdPad{1'b0}}, aid_i[i]};
    assign sbr_bus[i].rready  = rready_i[i];

    assign gnt_o[i]    = sbr_bus[i].gnt;
    assign rvalid_o[i] = sbr_bus[i].rvalid;
    assign rdata_o[i]  = sbr_bus[i].r.rdata;
    assign rid_o[i]    = sbr_bus[i].r.rid[obi_pkg::ObiSbrIdWidth-1:0];
    assign err_o[i]    = sbr_bus[i].r.err;
  end

  obi_mux #(
    .NumSbrPorts(NumSbrPorts),
    .NumMaxTrans(NumMaxTrans)
  ) i_mux (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .sbr_ports(sbr_bus),
    .mgr_port (mem_bus)
  );

  obi_sram #(
    .MemWords(MemWords)
  ) i_sram (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .bus  (mem_bus)
  );

endmodule

`default_nettype wire

// ==== obi_sram.sv ====
// Word-addressed SRAM as an OBI subordinate.
// One-entry response register; addresses past MemWords return err and zero
// data, and do not write.
`timescale 1ns/10ps
`default_nettype none

module obi_sram #(
  parameter int unsigned MemWords = 64
) (
  input wire logic clk_i,
  input wire logic rst_i,
  obi_if.sbr       bus
);

  localparam int unsigned MemIdxWidth = (MemWords > 1) ? $clog2(MemWords) : 1;
  localparam int unsigned WordLsb     = $clog2(obi_pkg::ObiDataWidth / 8);
  localparam int unsigned NumBytes    = obi_pkg::ObiDataWidth / 8;

  logic [obi_pkg::ObiDataWidth-1:0]         mem_q [MemWords];
  mem_pkg::mem_rsp_state_e                  rsp_state_q;
  obi_pkg::obi_r_chan_t                     rsp_q;

  logic [obi_pkg::ObiAddrWidth-WordLsb-1:0] word_idx;
  logic [MemIdxWidth-1:0]                   mem_idx;
  logic                                     in_range;
  logic                                     accept;
  mem_pkg::mem_op_e                         op;

  // byte address to word index
  assign word_idx = bus.a.addr[obi_pkg::ObiAddrWidth-1:WordLsb];
  assign in_range = (word_idx < MemWords);
  assign mem_idx  = word_idx[MemIdxWidth-1:0];
  assign op       = mem_pkg::mem_op_e'(bus.a.we);

  // free slot or the held response leaves this cycle
  assign bus.gnt = (rsp_state_q == mem_pkg::RSP_IDLE) || bus.rready;
  assign accept  = bus.req && bus.gnt;

  assign bus.rvalid = (rsp_state_q == mem_pkg::RSP_VALID);
  assign bus.r      = rsp_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_state_q <= mem_pkg::RSP_IDLE;
    end else if (accept) begin
      rsp_state_q <= mem_pkg::RSP_VALID;
    end else if (bus.rready) begin
      rsp_state_q <= mem_pkg::RSP_IDLE;
    end
  end

  // response payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_q.rid <= bus.a.aid;
      rsp_q.err <= !in_range;
      // writes and errors return zero data
      if (in_range && op == mem_pkg::MEM_READ) begin
        rsp_q.rdata <= mem_q[mem_idx];
      end else begin
        rsp_q.rdata <= '0;
      end
    end
  end

  // byte-enabled write
  always_ff @(posedge clk_i) begin
    if (accept && in_range && op == mem_pkg::MEM_WRITE) begin
      for (int b = 0; b < NumBytes; b++) begin
        if (bus.a.be[b]) begin
          mem_q[mem_idx][8*b +: 8] <= bus.a.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== obi_mux.sv ====
// OBI multiplexer, several subordinate ports onto one manager port.
// Round-robin arbitration on the A channel, the port index is placed above
// the port id, and responses are routed back in order through a FIFO.
`timescale 1ns/10ps
`default_nettype none

module obi_mux #(
  parameter int unsigned NumSbrPorts = 3,
  parameter int unsigned NumMaxTrans = 4
) (
  input wire logic clk_i,
  input wire logic rst_i,
  obi_if.sbr       sbr_ports [NumSbrPorts],
  obi_if.mgr       mgr_port
);

  localparam int unsigned IdxWidth = $clog2(NumSbrPorts);
  localparam int unsigned SbrIdW   = obi_pkg::ObiSbrIdWidth;

  if (NumSbrPorts < 2 || NumSbrPorts > 4) begin : gen_num_ports_err
    $fatal(1, "obi_mux: NumSbrPorts must be between 2 and 4");
  end

  logic [NumSbrPorts-1:0] sbr_req;
  logic [NumSbrPorts-1:0] sbr_gnt;
  logic [NumSbrPorts-1:0] sbr_rready;
  obi_pkg::obi_a_chan_t   sbr_a [NumSbrPorts];
  obi_pkg::obi_r_chan_t   rsp_r;

  logic                   arb_req;
  logic [IdxWidth-1:0]    sel_idx;
  logic [IdxWidth-1:0]    head_idx;
  logic                   fifo_full;
  logic                   fifo_empty;
  logic                   fifo_push;
  logic                   fifo_pop;

  // unpack the port array
  for (genvar i = 0; i < NumSbrPorts; i++) begin : gen_sbr_ports
    assign sbr_req[i]            = sbr_ports[i].req;
    assign sbr_a[i]              = sbr_ports[i].a;
    assign sbr_rready[i]         = sbr_ports[i].rready;
    assign sbr_ports[i].gnt      = sbr_gnt[i];
    // only the FIFO head owner sees the response
    assign sbr_ports[i].rvalid   = mgr_port.rvalid && (head_idx == IdxWidth'(i));
    assign sbr_ports[i].r        = rsp_r;
  end

  obi_rr_arbiter #(
    .NumSbrPorts(NumSbrPorts)
  ) i_arb (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .req_i(sbr_req),
    .gnt_i(mgr_port.gnt && !fifo_full),
    .gnt_o(sbr_gnt),
    .req_o(arb_req),
    .idx_o(sel_idx)
  );

  // no new request while the outstanding limit is reached
  assign mgr_port.req = arb_req && !fifo_full;

  // forward the winner, widened id = {port index, port id}
  always_comb begin
    mgr_port.a                              = sbr_a[sel_idx];
    mgr_port.a.aid                          = '0;
    mgr_port.a.aid[SbrIdW +: IdxWidth]      = sel_idx;
    mgr_port.a.aid[SbrIdW-1:0]              = sbr_a[sel_idx].aid[SbrIdW-1:0];
  end

  assign fifo_push = mgr_port.req && mgr_port.gnt;
  assign fifo_pop  = mgr_port.rvalid && mgr_port.rready;

  obi_id_fifo #(
    .NumMaxTrans(NumMaxTrans),
    .IdxWidth   (IdxWidth)
  ) i_id_fifo (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .push_i (fifo_push),
    .idx_i  (sel_idx),
    .pop_i  (fifo_pop),
    .idx_o  (head_idx),
    .full_o (fifo_full),
    .empty_o(fifo_empty)
  );

  // rready from the owner of the oldest transaction
  assign mgr_port.rready = !fifo_empty && sbr_rready[head_idx];

  // strip index bits on the way back
  always_comb begin
    rsp_r                  = mgr_port.r;
    rsp_r.rid              = '0;
    rsp_r.rid[SbrIdW-1:0]  = mgr_port.r.rid[SbrIdW-1:0];
  end

  // returned index must match the in-order routing
  a_rid_matches_head: assert property (@(posedge clk_i) disable iff (rst_i)
    mgr_port.rvalid |-> (mgr_port.r.rid[SbrIdW +: IdxWidth] == head_idx));

endmodule

`default_nettype wire

// ==== obi_id_fifo.sv ====
// In-order FIFO of granted port indices inside the OBI mux.
// Head gives the port owning the next response; depth caps outstanding
// transactions.
`timescale 1ns/10ps
`default_nettype none

module obi_id_fifo #(
  parameter int unsigned NumMaxTrans = 4,
  parameter int unsigned IdxWidth    = 2
) (
  input  wire logic                clk_i,
  input  wire logic                rst_i,
  input  wire logic                push_i,
  input  wire logic [IdxWidth-1:0] idx_i,
  input  wire logic                pop_i,
  output      logic [IdxWidth-1:0] idx_o,
  output      logic                full_o,
  output      logic                empty_o
);

  localparam int unsigned PtrWidth = (NumMaxTrans > 1) ? $clog2(NumMaxTrans) : 1;
  localparam int unsigned CntWidth = $clog2(NumMaxTrans + 1);

  logic [IdxWidth-1:0] mem_q [NumMaxTrans];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] cnt_q;

  // wrap at the depth, which need not be a power of two
  function automatic logic [PtrWidth-1:0] ptr_next(input logic [PtrWidth-1:0] p);
    return (p == PtrWidth'(NumMaxTrans - 1)) ? '0 : p + 1'b1;
  endfunction

  assign idx_o   = mem_q[rd_ptr_q];
  assign full_o  = (cnt_q == CntWidth'(NumMaxTrans));
  assign empty_o = (cnt_q == '0);

  // storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= idx_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      // fill level, simultaneous push and pop cancel
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i) push_i |-> !full_o);
  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== obi_rr_arbiter.sv ====
// Round-robin arbiter with lock-in for the OBI mux.
// Grant is combinational from the request vector; the pointer and lock
// update on the clock edge after each offered or accepted request.
`timescale 1ns/10ps
`default_nettype none

module obi_rr_arbiter #(
  parameter int unsigned NumSbrPorts = 3
) (
  input  wire logic                           clk_i,
  input  wire logic                           rst_i,
  input  wire logic [NumSbrPorts-1:0]         req_i,
  input  wire logic                           gnt_i,
  output      logic [NumSbrPorts-1:0]         gnt_o,
  output      logic                           req_o,
  output      logic [$clog2(NumSbrPorts)-1:0] idx_o
);

  localparam int unsigned IdxWidth = $clog2(NumSbrPorts);

  logic [IdxWidth-1:0] ptr_q;
  logic [IdxWidth-1:0] lock_idx_q;
  logic                lock_q;
  logic [IdxWidth-1:0] sel_idx;

  // first requester at or after the pointer, unless locked
  always_comb begin : proc_select
    logic        found;
    int unsigned cand;
    found   = 1'b0;
    sel_idx = ptr_q;
    for (int unsigned k = 0; k < NumSbrPorts; k++) begin
      cand = (ptr_q + k) % NumSbrPorts;
      if (!found && req_i[cand]) begin
        found   = 1'b1;
        sel_idx = IdxWidth'(cand);
      end
    end
    // offered request stays selected until granted
    if (lock_q) begin
      sel_idx = lock_idx_q;
    end
  end

  assign req_o = lock_q ? req_i[lock_idx_q] : |req_i;
  assign idx_o = sel_idx;

  always_comb begin
    gnt_o          = '0;
    gnt_o[sel_idx] = req_o & gnt_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (req_o && gnt_i) begin
      // accepted, move past the winner
      lock_q <= 1'b0;
      ptr_q  <= (sel_idx == NumSbrPorts - 1) ? '0 : sel_idx + 1'b1;
    end else if (req_o) begin
      // offered but stalled downstream
      lock_q     <= 1'b1;
      lock_idx_q <= sel_idx;
    end
  end

  // at most one input granted
  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(gnt_o));

  // upstream must not withdraw a request that was already offered
  a_lock_held: assert property (@(posedge clk_i) disable iff (rst_i)
    lock_q |-> req_i[lock_idx_q]);

endmodule

`default_nettype wire

// ==== obi_if.sv ====
// OBI bus bundle between the mux and the memory, and on each mux input.
// The mgr side issues requests, the sbr side grants and responds.
`timescale 1ns/10ps
`default_nettype none

interface obi_if;

  // A channel, req/gnt handshake
  logic                  req;
  logic                  gnt;
  obi_pkg::obi_a_chan_t  a;

  // R channel, rvalid/rready handshake
  logic                  rvalid;
  logic                  rready;
  obi_pkg::obi_r_chan_t  r;

  // requesting side
  modport mgr (
    output req,
    output a,
    output rready,
    input  gnt,
    input  rvalid,
    input  r
  );

  // responding side
  modport sbr (
    input  req,
    input  a,
    input  rready,
    output gnt,
    output rvalid,
    output r
  );

endinterface

`default_nettype wire

// ==== mem_pkg.sv ====
// Definitions for the SRAM subordinate behind the mux.
// Opcode and response register state, used by the memory and its model.
`default_nettype none

package mem_pkg;

  // access kind, taken straight from the we bit
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // one-entry response register
  typedef enum logic {
    RSP_IDLE  = 1'b0,
    RSP_VALID = 1'b1
  } mem_rsp_state_e;

endpackage

`default_nettype wire

// ==== obi_pkg.sv ====
// OBI bus definitions shared by every port of the mux subsystem.
// Widths and the A and R channel structs; referenced by scoped name.
`default_nettype none

package obi_pkg;

  // byte address and data widths
  localparam int unsigned ObiAddrWidth = 32;
  localparam int unsigned ObiDataWidth = 32;

  // id on a subordinate port
  localparam int unsigned ObiSbrIdWidth = 2;
  // widened id on the manager side, room for 2 index bits above the port id
  localparam int unsigned ObiMaxIdWidth = 4;

  // request channel
  typedef struct packed {
    logic [ObiAddrWidth-1:0]   addr;
    logic                      we;
    logic [ObiDataWidth/8-1:0] be;
    logic [ObiDataWidth-1:0]   wdata;
    // subordinate ports only fill the low ObiSbrIdWidth bits
    logic [ObiMaxIdWidth-1:0]  aid;
  } obi_a_chan_t;

  // response channel
  typedef struct packed {
    logic [ObiDataWidth-1:0]  rdata;
    logic [ObiMaxIdWidth-1:0] rid;
    logic                     err;
  } obi_r_chan_t;

endpackage

`default_nettype wire
